// ==== files.f ====
src/i3c_target_pkg.sv
src/bus_rx_flow.sv
src/bus_tx_flow.sv
src/target_fsm.sv
src/rx_credit_queue.sv
src/i3c_target_top.sv
test/tb_i3c_target.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_i3c_target -f files.f
./obj_dir/Vtb_i3c_target | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation reported no failure"

// ==== src/bus_rx_flow.sv ====
// Bus receiver that shifts SDA into a byte or a single bit on SCL rising edges
`timescale 1ns/1ps

module bus_rx_flow (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  i3c_target_pkg::bus_state_t  bus_i,
  input  logic                        rx_req_byte_i,
  input  logic                        rx_req_bit_i,
  output i3c_target_pkg::byte_t       rx_byte_o,
  output logic                        rx_bit_o,
  output logic                        rx_done_o
);

  localparam int unsigned BitsPerByte = i3c_target_pkg::BitsPerByte;
  localparam int unsigned CntW = $clog2(BitsPerByte + 1);

  logic [CntW-1:0]       bit_cnt_q;
  logic [CntW-1:0]       req_len;
  logic                  req_open;
  logic                  sample;
  logic                  done_q;
  i3c_target_pkg::byte_t shift_q;

  // A byte request wins if both are raised
  assign req_len  = rx_req_byte_i ? CntW'(BitsPerByte) : CntW'(1);
  assign req_open = (rx_req_byte_i | rx_req_bit_i) & ~done_q;
  assign sample   = req_open & bus_i.scl_pos;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (bus_i.start_det || bus_i.stop_det) begin
        bit_cnt_q <= '0;
      end else if (sample) begin
        if (bit_cnt_q + 1'b1 == req_len) begin
          bit_cnt_q <= '0;
          done_q    <= 1'b1;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end
    end
  end

  // MSB first, as on the wire
  always_ff @(posedge clk_i) begin
    if (sample) begin
      shift_q <= {shift_q[BitsPerByte-2:0], bus_i.sda};
    end
  end

  assign rx_byte_o = shift_q;
  assign rx_bit_o  = shift_q[0];
  assign rx_done_o = done_q;

endmodule

// ==== src/bus_tx_flow.sv ====
// Open-drain SDA driver for single requested bits with data hold timing
`timescale 1ns/1ps

module bus_tx_flow (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  i3c_target_pkg::bus_state_t  bus_i,
  input  i3c_target_pkg::hold_cnt_t   t_hd_dat_i,
  input  logic                        tx_req_bit_i,
  input  logic                        tx_value_i,
  output logic                        tx_done_o,
  output logic                        sda_o
);

  typedef enum logic [2:0] {
    TxIdle,
    TxWaitNeg1,
    TxHold,
    TxDrive,
    TxWaitNeg2,
    TxRelease
  } tx_state_e;

  tx_state_e                 state_q;
  i3c_target_pkg::hold_cnt_t hold_cnt_q;
  logic                      value_q;
  logic                      done_q;
  logic                      req_accept;
  logic                      hold_over;

  // Requester keeps its level up until it sees done
  assign req_accept = (state_q == TxIdle) & tx_req_bit_i & ~done_q;
  assign hold_over  = hold_cnt_q <= i3c_target_pkg::hold_cnt_t'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= TxIdle;
      hold_cnt_q <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (bus_i.start_det || bus_i.stop_det) begin
        state_q <= TxIdle;
      end else begin
        case (state_q)
          TxIdle: begin
            if (req_accept) state_q <= TxWaitNeg1;
          end
          TxWaitNeg1: begin
            if (bus_i.scl_neg) begin
              hold_cnt_q <= t_hd_dat_i;
              state_q    <= TxHold;
            end
          end
          TxHold: begin
            if (hold_over) state_q <= TxDrive;
            else hold_cnt_q <= hold_cnt_q - 1'b1;
          end
          // Controller samples the bit here
          TxDrive: begin
            if (bus_i.scl_pos) state_q <= TxWaitNeg2;
          end
          TxWaitNeg2: begin
            if (bus_i.scl_neg) begin
              hold_cnt_q <= t_hd_dat_i;
              state_q    <= TxRelease;
            end
          end
          TxRelease: begin
            if (hold_over) begin
              state_q <= TxIdle;
              done_q  <= 1'b1;
            end else begin
              hold_cnt_q <= hold_cnt_q - 1'b1;
            end
          end
          default: state_q <= TxIdle;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_accept) value_q <= tx_value_i;
  end

  assign sda_o     = (state_q inside {TxDrive, TxWaitNeg2, TxRelease}) ? value_q : 1'b1;
  assign tx_done_o = done_q;

endmodule

// ==== src/i3c_target_pkg.sv ====
// I3C standby target types, configuration layout and protocol constants
package i3c_target_pkg;

  localparam int unsigned BitsPerByte = 8;

  // Ninth bit value a target drives to acknowledge
  localparam logic AckBit = 1'b0;
  // RnW value of a private write header
  localparam logic RnwWrite = 1'b0;

  // Host side queue defaults
  localparam int unsigned RxFifoDepthDefault = 4;
  localparam int unsigned RxCreditsDefault = 2;

  typedef logic [BitsPerByte-1:0] byte_t;
  typedef logic [6:0] addr7_t;
  typedef logic [7:0] hold_cnt_t;

  // Per-clock bus events from the PHY sampler
  typedef struct packed {
    logic start_det;
    logic stop_det;
    logic scl_pos;
    logic scl_neg;
    logic sda;
  } bus_state_t;

  typedef struct packed {
    addr7_t    dyn_addr;
    logic      dyn_addr_valid;
    addr7_t    sta_addr;
    logic      sta_addr_valid;
    hold_cnt_t t_hd_dat;
  } target_cfg_t;

endpackage

// ==== src/i3c_target_top.sv ====
// I3C standby target write path from bus events to the host receive queue
`timescale 1ns/1ps

module i3c_target_top #(
  parameter int unsigned RxFifoDepth = i3c_target_pkg::RxFifoDepthDefault,
  parameter int unsigned RxCredits   = i3c_target_pkg::RxCreditsDefault
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  i3c_target_pkg::bus_state_t  ctrl_bus_i,
  input  i3c_target_pkg::target_cfg_t target_cfg_i,
  output logic                        ctrl_sda_o,
  output logic                        rx_valid_o,
  output i3c_target_pkg::byte_t       rx_data_o,
  input  logic                        rx_credit_i,
  output logic                        rx_overflow_o,
  output i3c_target_pkg::byte_t       bus_addr_o,
  output logic                        bus_addr_valid_o,
  output logic                        parity_err_o
);

  logic                  rx_req_byte;
  logic                  rx_req_bit;
  i3c_target_pkg::byte_t rx_byte;
  logic                  rx_bit;
  logic                  rx_byte_done;
  logic                  tx_req_bit;
  logic                  tx_value;
  logic                  tx_done;
  logic                  q_push;
  i3c_target_pkg::byte_t q_data;

  bus_rx_flow u_bus_rx_flow (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .bus_i         (ctrl_bus_i),
    .rx_req_byte_i (rx_req_byte),
    .rx_req_bit_i  (rx_req_bit),
    .rx_byte_o     (rx_byte),
    .rx_bit_o      (rx_bit),
    .rx_done_o     (rx_byte_done)
  );

  target_fsm u_target_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bus_i            (ctrl_bus_i),
    .cfg_i            (target_cfg_i),
    .rx_req_byte_o    (rx_req_byte),
    .rx_req_bit_o     (rx_req_bit),
    .rx_byte_i        (rx_byte),
    .rx_bit_i         (rx_bit),
    .rx_done_i        (rx_byte_done),
    .tx_req_bit_o     (tx_req_bit),
    .tx_value_o       (tx_value),
    .tx_done_i        (tx_done),
    .q_push_o         (q_push),
    .q_data_o         (q_data),
    .bus_addr_o       (bus_addr_o),
    .bus_addr_valid_o (bus_addr_valid_o),
    .parity_err_o     (parity_err_o)
  );

  bus_tx_flow u_bus_tx_flow (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bus_i        (ctrl_bus_i),
    .t_hd_dat_i   (target_cfg_i.t_hd_dat),
    .tx_req_bit_i (tx_req_bit),
    .tx_value_i   (tx_value),
    .tx_done_o    (tx_done),
    .sda_o        (ctrl_sda_o)
  );

  rx_credit_queue #(
    .RxFifoDepth (RxFifoDepth),
    .RxCredits   (RxCredits)
  ) u_rx_credit_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bus_start_i (ctrl_bus_i.start_det),
    .push_i      (q_push),
    .data_i      (q_data),
    .credit_i    (rx_credit_i),
    .rx_valid_o  (rx_valid_o),
    .rx_data_o   (rx_data_o),
    .overflow_o  (rx_overflow_o)
  );

endmodule

// ==== src/rx_credit_queue.sv ====
// Receive FIFO that hands bytes to the host against returned credits
`timescale 1ns/1ps

module rx_credit_queue #(
  parameter int unsigned RxFifoDepth = i3c_target_pkg::RxFifoDepthDefault,
  parameter int unsigned RxCredits   = i3c_target_pkg::RxCreditsDefault
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  bus_start_i,
  input  logic                  push_i,
  input  i3c_target_pkg::byte_t data_i,
  input  logic                  credit_i,
  output logic                  rx_valid_o,
  output i3c_target_pkg::byte_t rx_data_o,
  output logic                  overflow_o
);

  localparam int unsigned PtrW = $clog2(RxFifoDepth);
  localparam int unsigned CntW = $clog2(RxFifoDepth + 1);
  localparam int unsigned CrW  = $clog2(RxCredits + 1);

  i3c_target_pkg::byte_t mem_q [RxFifoDepth];
  i3c_target_pkg::byte_t rx_data_q;
  logic [PtrW-1:0]       wr_ptr_q;
  logic [PtrW-1:0]       rd_ptr_q;
  logic [CntW-1:0]       fill_q;
  logic [CrW-1:0]        credit_q;
  logic                  rx_valid_q;
  logic                  overflow_q;
  logic                  empty;
  logic                  full;
  logic                  has_credit;
  logic                  bypass;
  logic                  pop;
  logic                  wr_en;

  assign empty      = fill_q == '0;
  assign full       = fill_q == CntW'(RxFifoDepth);
  assign has_credit = credit_q != '0;

  // Empty queue with credit in hand passes the byte straight out
  assign bypass = push_i & empty & has_credit;
  assign pop    = ~empty & has_credit;
  assign wr_en  = push_i & ~full & ~bypass;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fill_q     <= '0;
      credit_q   <= CrW'(RxCredits);
      rx_valid_q <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      rx_valid_q <= pop | bypass;
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(RxFifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(RxFifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr_en, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: ;
      endcase
      case ({pop | bypass, credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: ;
      endcase
      // Drop on full wins over the clear at START
      if (push_i && full) overflow_q <= 1'b1;
      else if (bus_start_i) overflow_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) mem_q[wr_ptr_q] <= data_i;
    if (pop) rx_data_q <= mem_q[rd_ptr_q];
    else if (bypass) rx_data_q <= data_i;
  end

  assign rx_valid_o = rx_valid_q;
  assign rx_data_o  = rx_data_q;
  assign overflow_o = overflow_q;

endmodule

// ==== src/target_fsm.sv ====
// Target transfer FSM for address match, ACK, write data and T-bit parity
`timescale 1ns/1ps

module target_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  i3c_target_pkg::bus_state_t  bus_i,
  input  i3c_target_pkg::target_cfg_t cfg_i,
  output logic                        rx_req_byte_o,
  output logic                        rx_req_bit_o,
  input  i3c_target_pkg::byte_t       rx_byte_i,
  input  logic                        rx_bit_i,
  input  logic                        rx_done_i,
  output logic                        tx_req_bit_o,
  output logic                        tx_value_o,
  input  logic                        tx_done_i,
  output logic                        q_push_o,
  output i3c_target_pkg::byte_t       q_data_o,
  output i3c_target_pkg::byte_t       bus_addr_o,
  output logic                        bus_addr_valid_o,
  output logic                        parity_err_o
);

  typedef enum logic [2:0] {
    Idle,
    Addr,
    Ack,
    NackSkip,
    DataByte,
    TBit,
    WaitStop
  } state_e;

  state_e                state_q;
  i3c_target_pkg::byte_t addr_q;
  i3c_target_pkg::byte_t data_q;
  logic                  addr_valid_q;
  logic                  push_q;
  logic                  perr_q;
  logic                  dyn_hit;
  logic                  sta_hit;
  logic                  addr_match;
  logic                  parity_ok;

  assign dyn_hit = cfg_i.dyn_addr_valid & (rx_byte_i[7:1] == cfg_i.dyn_addr);
  assign sta_hit = cfg_i.sta_addr_valid & (rx_byte_i[7:1] == cfg_i.sta_addr);

  // Only private writes are acknowledged
  assign addr_match = (dyn_hit | sta_hit) & (rx_byte_i[0] == i3c_target_pkg::RnwWrite);

  // T bit carries odd parity over the data byte
  assign parity_ok = rx_bit_i == ~(^data_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      addr_valid_q <= 1'b0;
      push_q       <= 1'b0;
      perr_q       <= 1'b0;
    end else begin
      addr_valid_q <= 1'b0;
      push_q       <= 1'b0;
      perr_q       <= 1'b0;
      if (bus_i.start_det) begin
        state_q <= Addr;
      end else if (bus_i.stop_det) begin
        state_q <= Idle;
      end else begin
        case (state_q)
          Addr: begin
            if (rx_done_i) begin
              addr_valid_q <= 1'b1;
              state_q      <= addr_match ? Ack : NackSkip;
            end
          end
          Ack: begin
            if (tx_done_i) state_q <= DataByte;
          end
          // Ninth bit stays released
          NackSkip: begin
            if (bus_i.scl_pos) state_q <= WaitStop;
          end
          DataByte: begin
            if (rx_done_i) state_q <= TBit;
          end
          TBit: begin
            if (rx_done_i) begin
              push_q  <= parity_ok;
              perr_q  <= ~parity_ok;
              state_q <= DataByte;
            end
          end
          // Idle and WaitStop leave only on START or STOP
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == Addr && rx_done_i) addr_q <= rx_byte_i;
    if (state_q == DataByte && rx_done_i) data_q <= rx_byte_i;
  end

  assign rx_req_byte_o    = state_q inside {Addr, DataByte};
  assign rx_req_bit_o     = state_q == TBit;
  assign tx_req_bit_o     = state_q == Ack;
  assign tx_value_o       = i3c_target_pkg::AckBit;
  assign q_push_o         = push_q;
  assign q_data_o         = data_q;
  assign bus_addr_o       = addr_q;
  assign bus_addr_valid_o = addr_valid_q;
  assign parity_err_o     = perr_q;

endmodule

// ==== test/tb_i3c_target.sv ====
// Testbench for the I3C target write path with a bus driver, a host credit model and a scoreboard
`timescale 1ns/1ps

module tb_i3c_target;

  localparam int unsigned RxFifoDepth = i3c_target_pkg::RxFifoDepthDefault;
  localparam int unsigned RxCredits   = i3c_target_pkg::RxCreditsDefault;
  localparam int unsigned Capacity    = RxCredits + RxFifoDepth;
  localparam i3c_target_pkg::addr7_t DynAddr   = 7'h2A;
  localparam i3c_target_pkg::addr7_t StaAddr   = 7'h51;
  localparam i3c_target_pkg::addr7_t OtherAddr = 7'h33;
  // Headers plus data bytes over all transfers, 9 bits each
  localparam int unsigned TotalBits = 252;
  localparam int unsigned MarginNs  = 20000;

  logic                        clk = 1'b0;
  logic                        rst_n;
  i3c_target_pkg::bus_state_t  ctrl_bus;
  i3c_target_pkg::target_cfg_t target_cfg;
  logic                        rx_credit;
  logic                        ctrl_sda;
  logic                        rx_valid;
  i3c_target_pkg::byte_t       rx_data;
  logic                        rx_overflow;
  i3c_target_pkg::byte_t       bus_addr;
  logic                        bus_addr_valid;
  logic                        parity_err;

  i3c_target_pkg::byte_t exp_q[$];
  i3c_target_pkg::byte_t exp_addr;
  logic [31:0]           rng_state = 32'd39777;
  int                    recv_cnt = 0;
  int                    addr_cnt = 0;
  int                    perr_cnt = 0;
  int                    outstanding = 0;
  int                    gap_cnt = 0;
  int                    base_cnt;
  logic                  credit_en = 1'b1;
  logic                  ack_window = 1'b0;

  i3c_target_top i3c_target_top_inst (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .ctrl_bus_i       (ctrl_bus),
    .target_cfg_i     (target_cfg),
    .ctrl_sda_o       (ctrl_sda),
    .rx_valid_o       (rx_valid),
    .rx_data_o        (rx_data),
    .rx_credit_i      (rx_credit),
    .rx_overflow_o    (rx_overflow),
    .bus_addr_o       (bus_addr),
    .bus_addr_valid_o (bus_addr_valid),
    .parity_err_o     (parity_err)
  );

  always #5 clk = ~clk;

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  function automatic i3c_target_pkg::byte_t rand_byte();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[23:16];
  endfunction

  // T bit makes the count of ones over byte and T odd
  function automatic logic t_bit_for(input i3c_target_pkg::byte_t data);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < 8; i++) begin
      if (data[i]) ones++;
    end
    return (ones % 2) == 0;
  endfunction

  task automatic drive_events(input logic start, input logic stop, input logic pos,
                              input logic neg);
    @(posedge clk);
    #1;
    ctrl_bus.start_det = start;
    ctrl_bus.stop_det  = stop;
    ctrl_bus.scl_pos   = pos;
    ctrl_bus.scl_neg   = neg;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) drive_events(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  // Falling edge, 4 idle, rising edge with SDA, 4 idle
  task automatic send_bit(input logic value, output logic sda_seen);
    drive_events(1'b0, 1'b0, 1'b0, 1'b1);
    ctrl_bus.sda = value;
    idle(4);
    drive_events(1'b0, 1'b0, 1'b1, 1'b0);
    @(negedge clk);
    sda_seen = ctrl_sda;
    idle(4);
  endtask

  task automatic send_start();
    ack_window = 1'b0;
    drive_events(1'b1, 1'b0, 1'b0, 1'b0);
    idle(2);
  endtask

  task automatic send_stop();
    ack_window = 1'b0;
    drive_events(1'b0, 1'b1, 1'b0, 1'b0);
    idle(2);
  endtask

  task automatic send_header(input i3c_target_pkg::addr7_t addr, input logic rnw,
                             input logic exp_ack);
    logic seen;
    int   addr_before;
    int   i;
    exp_addr    = {addr, rnw};
    addr_before = addr_cnt;
    for (i = 7; i >= 0; i--) begin
      send_bit(exp_addr[i], seen);
    end
    assert (addr_cnt == addr_before + 1)
      else report_error("bus_addr_valid_o did not pulse once for the header");
    ack_window = exp_ack;
    send_bit(1'b1, seen);
    assert (seen == !exp_ack)
      else report_error($sformatf("ctrl_sda_o = %0b at ninth bit, ACK expected %0b",
                                  seen, exp_ack));
  endtask

  task automatic send_byte(input i3c_target_pkg::byte_t data, input logic bad_t,
                           input logic acked, input logic keep);
    logic seen;
    logic t_bit;
    int   perr_before;
    int   i;
    t_bit       = t_bit_for(data) ^ bad_t;
    perr_before = perr_cnt;
    // Delivery can start within the T bit, so the entry goes in first
    if (acked && !bad_t && keep) exp_q.push_back(data);
    for (i = 7; i >= 0; i--) begin
      send_bit(data[i], seen);
      ack_window = 1'b0;
    end
    send_bit(t_bit, seen);
    assert (perr_cnt == perr_before + int'(acked && bad_t))
      else report_error("parity_err_o count does not match the T bit");
  endtask

  task automatic send_nack_transfer(input i3c_target_pkg::addr7_t addr, input logic rnw);
    send_start();
    send_header(addr, rnw, 1'b0);
    send_byte(rand_byte(), 1'b0, 1'b0, 1'b0);
    send_stop();
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 || outstanding != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > 400) report_error("expected bytes never arrived on rx_valid_o");
    end
  endtask

  task automatic check_outputs_idle(input string when_str);
    assert (ctrl_sda && !rx_valid && !bus_addr_valid && !parity_err && !rx_overflow)
      else report_error({"outputs not in their idle state ", when_str});
  endtask

  // Host returns one credit every third cycle while it holds bytes
  always @(posedge clk) begin
    #1;
    rx_credit = 1'b0;
    if (gap_cnt != 0) begin
      gap_cnt--;
    end else if (credit_en && outstanding > 0) begin
      rx_credit = 1'b1;
      outstanding--;
      gap_cnt = 2;
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      if (rx_valid) begin
        assert (exp_q.size() > 0) else report_error("rx_valid_o with no byte expected");
        assert (rx_data == exp_q[0])
          else report_error($sformatf("rx_data_o = %02h, expected %02h", rx_data, exp_q[0]));
        void'(exp_q.pop_front());
        recv_cnt++;
        outstanding++;
      end
      if (bus_addr_valid) begin
        assert (bus_addr == exp_addr)
          else report_error($sformatf("bus_addr_o = %02h, expected %02h", bus_addr, exp_addr));
        addr_cnt++;
      end
      if (parity_err) perr_cnt++;
    end
  end

  credit_limit_a: assert property (@(posedge clk) disable iff (!rst_n)
                                   outstanding <= int'(RxCredits))
    else report_error("host holds more bytes than it has credits");

  sda_window_a: assert property (@(posedge clk) disable iff (!rst_n) !ctrl_sda |-> ack_window)
    else report_error("ctrl_sda_o pulled low outside an ACK bit");

  initial begin
    #(TotalBits * 10 * 10 + MarginNs);
    $display("Watchdog: the run timed out before all tests finished");
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

  initial begin
    rst_n                     = 1'b0;
    ctrl_bus                  = '0;
    ctrl_bus.sda              = 1'b1;
    rx_credit                 = 1'b0;
    target_cfg.dyn_addr       = DynAddr;
    target_cfg.dyn_addr_valid = 1'b1;
    target_cfg.sta_addr       = StaAddr;
    target_cfg.sta_addr_valid = 1'b0;
    target_cfg.t_hd_dat       = 8'd2;
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_outputs_idle("during reset");
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    idle(4);
    @(negedge clk);
    check_outputs_idle("after reset");

    // Matched private write
    send_start();
    send_header(DynAddr, 1'b0, 1'b1);
    repeat (3) send_byte(rand_byte(), 1'b0, 1'b1, 1'b1);
    send_stop();
    wait_drained();

    // Wrong address, read header, invalid static address
    send_nack_transfer(OtherAddr, 1'b0);
    send_nack_transfer(DynAddr, 1'b1);
    send_nack_transfer(StaAddr, 1'b0);
    idle(10);

    // Bad T bit between two good bytes
    send_start();
    send_header(DynAddr, 1'b0, 1'b1);
    send_byte(rand_byte(), 1'b0, 1'b1, 1'b1);
    send_byte(rand_byte(), 1'b1, 1'b1, 1'b1);
    send_byte(rand_byte(), 1'b0, 1'b1, 1'b1);
    send_stop();
    wait_drained();

    // Credits withheld
    credit_en = 1'b0;
    base_cnt  = recv_cnt;
    send_start();
    send_header(DynAddr, 1'b0, 1'b1);
    repeat (4) send_byte(rand_byte(), 1'b0, 1'b1, 1'b1);
    idle(10);
    assert (recv_cnt - base_cnt == int'(RxCredits))
      else report_error($sformatf("%0d bytes delivered without credit return",
                                  recv_cnt - base_cnt));
    credit_en = 1'b1;
    send_stop();
    wait_drained();

    // More bytes than credits plus FIFO entries
    credit_en = 1'b0;
    send_start();
    send_header(DynAddr, 1'b0, 1'b1);
    for (int n = 0; n < int'(Capacity) + 2; n++) begin
      send_byte(rand_byte(), 1'b0, 1'b1, n < int'(Capacity));
    end
    @(negedge clk);
    assert (rx_overflow) else report_error("rx_overflow_o not set on a full FIFO");
    credit_en = 1'b1;
    send_stop();
    wait_drained();
    idle(10);
    assert (rx_overflow) else report_error("rx_overflow_o cleared before START");
    send_start();
    @(negedge clk);
    assert (!rx_overflow) else report_error("rx_overflow_o not cleared by START");
    send_stop();

    idle(5);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
